// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

  typedef logic [3:0] nibble_t;
  typedef logic [7:0] code_addr_t;
  typedef logic [7:0] data_addr_t;
  typedef logic [11:0] instr_word_t;

  // instruction bits 11:8
  typedef enum logic [3:0] {
    OP_NOP, OP_LDI, OP_ADDI, OP_ADD,
    OP_AND, OP_OR, OP_XOR, OP_SUB,
    OP_LD, OP_LDPX, OP_ST, OP_JP,
    OP_JPZ, OP_JPC, OP_EIDI, OP_RETI
  } opcode_e;

  // instruction bits 5:4
  typedef enum logic [1:0] {REG_A, REG_B, REG_XL, REG_XH} reg_sel_e;

  typedef enum logic [2:0] {
    ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR
  } alu_op_e;

  // imm[3:0] for nibble operands, imm[7:0] for jump targets
  typedef struct packed {
    opcode_e opcode;
    reg_sel_e reg_sel;
    logic [7:0] imm;
    logic is_jump;
    logic is_mem;
  } decoded_t;

endpackage

`default_nettype wire

// File: verilog/uarch_pkg.sv
`default_nettype none

package uarch_pkg;

  // number of execute steps, 1 or 2
  typedef logic [1:0] instr_length_t;

  typedef enum logic [1:0] {PC_SRC_IMM, PC_SRC_VECTOR, PC_SRC_SAVED} pc_src_e;

  typedef struct packed {
    isa_pkg::alu_op_e alu_op;
    logic operand_imm;
    isa_pkg::reg_sel_e dest;
    logic reg_we;
    logic flags_we;
    logic x_inc;
    logic pc_inc;
    logic pc_load;
    pc_src_e pc_src;
    logic save_pc;
    logic int_en_we;
    logic int_en_value;
    logic mem_read;
    logic mem_write;
  } micro_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  isa_pkg::alu_op_e op,
  input  isa_pkg::nibble_t temp_a,
  input  isa_pkg::nibble_t temp_b,
  input  logic             carry_in,
  output isa_pkg::nibble_t out,
  output logic             carry_out,
  output logic             zero_out
);
  import isa_pkg::*;

  logic [4:0] sum;
  logic [4:0] diff;

  assign sum = {1'b0, temp_a} + {1'b0, temp_b};
  // bit 4 is the borrow
  assign diff = {1'b0, temp_a} - {1'b0, temp_b};

  always_comb begin
    out = temp_b;
    carry_out = carry_in;
    case (op)
      ALU_ADD: begin
        out = sum[3:0];
        carry_out = sum[4];
      end
      ALU_SUB: begin
        out = diff[3:0];
        carry_out = diff[4];
      end
      ALU_AND: out = temp_a & temp_b;
      ALU_OR: out = temp_a | temp_b;
      ALU_XOR: out = temp_a ^ temp_b;
      default: out = temp_b;
    endcase
  end

  assign zero_out = (out == 4'd0);

endmodule

`default_nettype wire

// File: verilog/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
  input  logic                     clk,
  input  logic                     clk_en,
  input  logic                     rst_n,
  input  logic                     fetch,
  input  isa_pkg::instr_word_t     rom_data,
  output isa_pkg::decoded_t        decoded,
  output uarch_pkg::instr_length_t cycle_length
);
  import isa_pkg::*;

  instr_word_t instr;
  opcode_e opcode;

  // instruction register, all zero decodes as NOP
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr <= '0;
    end else if (clk_en && fetch) begin
      instr <= rom_data;
    end
  end

  assign opcode = opcode_e'(instr[11:8]);

  always_comb begin
    decoded.opcode = opcode;
    decoded.reg_sel = reg_sel_e'(instr[5:4]);
    decoded.imm = instr[7:0];
    decoded.is_jump = opcode inside {OP_JP, OP_JPZ, OP_JPC};
    decoded.is_mem = opcode inside {OP_LD, OP_LDPX, OP_ST};
  end

  // LDPX needs a second step for the X increment
  assign cycle_length = (opcode == OP_LDPX) ? 2'd2 : 2'd1;

endmodule

`default_nettype wire

// File: verilog/microcode.sv
`timescale 1ns/1ps
`default_nettype none

module microcode #(
  parameter int int_count = 4
) (
  input  logic                     clk,
  input  logic                     clk_en,
  input  logic                     rst_n,
  input  isa_pkg::decoded_t        decoded,
  input  uarch_pkg::instr_length_t cycle_length,
  input  logic                     flag_zero,
  input  logic                     flag_carry,
  input  logic                     flag_interrupt,
  input  logic [int_count-1:0]     interrupt_req,
  output logic                     fetch,
  output isa_pkg::code_addr_t      int_vector,
  output uarch_pkg::micro_ctrl_t   ctrl
);
  import isa_pkg::*;
  import uarch_pkg::*;

  typedef enum logic [1:0] {ST_FETCH, ST_EXEC, ST_POST, ST_INT_ENTRY} state_e;

  state_e state;
  instr_length_t step;
  logic int_take;
  logic jump_taken;

  // lowest pending line wins, vector 0 is reset
  always_comb begin
    int_vector = '0;
    for (int i = int_count - 1; i >= 0; i--) begin
      if (interrupt_req[i]) begin
        int_vector = code_addr_t'(i + 1);
      end
    end
  end

  assign int_take = flag_interrupt && (|interrupt_req);

  assign jump_taken = (decoded.opcode == OP_JP) ||
                      (decoded.opcode == OP_JPZ && flag_zero) ||
                      (decoded.opcode == OP_JPC && flag_carry);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_FETCH;
      step <= '0;
    end else if (clk_en) begin
      case (state)
        ST_FETCH: begin
          state <= ST_EXEC;
          step <= 2'd1;
        end
        ST_EXEC, ST_POST: begin
          if (step < cycle_length) begin
            state <= ST_POST;
            step <= step + 1'b1;
          end else begin
            state <= int_take ? ST_INT_ENTRY : ST_FETCH;
            step <= '0;
          end
        end
        default: state <= ST_FETCH;
      endcase
    end
  end

  assign fetch = (state == ST_FETCH);

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = ALU_PASS;
    ctrl.dest = decoded.reg_sel;
    ctrl.pc_src = PC_SRC_IMM;
    case (state)
      ST_FETCH: ctrl.pc_inc = 1'b1;
      ST_POST: ctrl.x_inc = 1'b1;
      ST_INT_ENTRY: begin
        ctrl.save_pc = 1'b1;
        ctrl.int_en_we = 1'b1;
        ctrl.int_en_value = 1'b0;
        ctrl.pc_load = 1'b1;
        ctrl.pc_src = PC_SRC_VECTOR;
      end
      default: begin
        if (decoded.is_jump) begin
          ctrl.pc_load = jump_taken;
        end
        // memory ops always move data between A and [X]
        if (decoded.is_mem) begin
          ctrl.dest = REG_A;
          ctrl.mem_write = (decoded.opcode == OP_ST);
          ctrl.mem_read = !ctrl.mem_write;
          ctrl.reg_we = !ctrl.mem_write;
        end
        case (decoded.opcode)
          OP_LDI: begin
            ctrl.operand_imm = 1'b1;
            ctrl.reg_we = 1'b1;
          end
          OP_ADDI: begin
            ctrl.alu_op = ALU_ADD;
            ctrl.operand_imm = 1'b1;
            ctrl.reg_we = 1'b1;
            ctrl.flags_we = 1'b1;
          end
          OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
            ctrl.dest = REG_A;
            ctrl.reg_we = 1'b1;
            ctrl.flags_we = 1'b1;
            case (decoded.opcode)
              OP_ADD: ctrl.alu_op = ALU_ADD;
              OP_SUB: ctrl.alu_op = ALU_SUB;
              OP_AND: ctrl.alu_op = ALU_AND;
              OP_OR: ctrl.alu_op = ALU_OR;
              default: ctrl.alu_op = ALU_XOR;
            endcase
          end
          OP_EIDI: begin
            ctrl.int_en_we = 1'b1;
            ctrl.int_en_value = decoded.imm[0];
          end
          OP_RETI: begin
            ctrl.pc_load = 1'b1;
            ctrl.pc_src = PC_SRC_SAVED;
            ctrl.int_en_we = 1'b1;
            ctrl.int_en_value = 1'b1;
          end
          default: ;
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/regs.sv
`timescale 1ns/1ps
`default_nettype none

module regs (
  input  logic                   clk,
  input  logic                   clk_en,
  input  logic                   rst_n,
  input  uarch_pkg::micro_ctrl_t ctrl,
  input  isa_pkg::decoded_t      decoded,
  input  isa_pkg::code_addr_t    int_vector,
  input  isa_pkg::nibble_t       alu,
  input  logic                   alu_zero,
  input  logic                   alu_carry,
  input  isa_pkg::nibble_t       memory_read_data,
  output logic                   memory_read_en,
  output logic                   memory_write_en,
  output isa_pkg::data_addr_t    memory_addr,
  output isa_pkg::nibble_t       memory_write_data,
  output isa_pkg::code_addr_t    pc,
  output isa_pkg::nibble_t       temp_a,
  output isa_pkg::nibble_t       temp_b,
  output logic                   zero,
  output logic                   carry,
  output logic                   interrupt
);
  import isa_pkg::*;
  import uarch_pkg::*;

  nibble_t a;
  nibble_t b;
  data_addr_t x;
  code_addr_t saved_pc;
  code_addr_t pc_next;
  nibble_t bus;
  nibble_t [3:0] reg_view;

  // indexed by reg_sel_e
  assign reg_view = {x[7:4], x[3:0], b, a};

  assign temp_a = reg_view[ctrl.dest];
  assign temp_b = ctrl.operand_imm ? decoded.imm[3:0] : reg_view[decoded.reg_sel];

  // write-back comes from memory on loads, otherwise from the ALU
  assign bus = ctrl.mem_read ? memory_read_data : alu;

  always_comb begin
    pc_next = pc;
    if (ctrl.pc_load) begin
      case (ctrl.pc_src)
        PC_SRC_VECTOR: pc_next = int_vector;
        PC_SRC_SAVED: pc_next = saved_pc;
        default: pc_next = decoded.imm;
      endcase
    end else if (ctrl.pc_inc) begin
      pc_next = pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a <= '0;
      b <= '0;
      x <= '0;
      pc <= '0;
      zero <= 1'b0;
      carry <= 1'b0;
      interrupt <= 1'b0;
    end else if (clk_en) begin
      pc <= pc_next;
      if (ctrl.x_inc) begin
        x <= x + 1'b1;
      end
      if (ctrl.reg_we) begin
        case (ctrl.dest)
          REG_A: a <= bus;
          REG_B: b <= bus;
          REG_XL: x[3:0] <= bus;
          default: x[7:4] <= bus;
        endcase
      end
      if (ctrl.flags_we) begin
        zero <= alu_zero;
        carry <= alu_carry;
      end
      if (ctrl.int_en_we) begin
        interrupt <= ctrl.int_en_value;
      end
    end
  end

  // single level, no nesting
  always_ff @(posedge clk) begin
    if (clk_en && ctrl.save_pc) begin
      saved_pc <= pc;
    end
  end

  assign memory_addr = x;
  assign memory_read_en = ctrl.mem_read;
  assign memory_write_en = ctrl.mem_write;
  assign memory_write_data = a;

endmodule

`default_nettype wire

// File: verilog/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
  parameter int int_count = 4
) (
  input  logic                 clk,
  input  logic                 clk_en,
  input  logic                 rst_n,
  output isa_pkg::code_addr_t  rom_addr,
  input  isa_pkg::instr_word_t rom_data,
  output logic                 memory_read_en,
  output logic                 memory_write_en,
  output isa_pkg::data_addr_t  memory_addr,
  output isa_pkg::nibble_t     memory_write_data,
  input  isa_pkg::nibble_t     memory_read_data,
  input  logic [int_count-1:0] interrupt_req
);
  import isa_pkg::*;
  import uarch_pkg::*;

  logic fetch;
  decoded_t decoded;
  instr_length_t cycle_length;
  micro_ctrl_t ctrl;
  code_addr_t int_vector;

  logic flag_zero;
  logic flag_carry;
  logic flag_interrupt;

  nibble_t temp_a;
  nibble_t temp_b;
  nibble_t alu_out;
  logic alu_carry_out;
  logic alu_zero_out;

  decode decoder (
    .clk(clk),
    .clk_en(clk_en),
    .rst_n(rst_n),
    .fetch(fetch),
    .rom_data(rom_data),
    .decoded(decoded),
    .cycle_length(cycle_length)
  );

  microcode #(
    .int_count(int_count)
  ) microcode (
    .clk(clk),
    .clk_en(clk_en),
    .rst_n(rst_n),
    .decoded(decoded),
    .cycle_length(cycle_length),
    .flag_zero(flag_zero),
    .flag_carry(flag_carry),
    .flag_interrupt(flag_interrupt),
    .interrupt_req(interrupt_req),
    .fetch(fetch),
    .int_vector(int_vector),
    .ctrl(ctrl)
  );

  alu alu (
    .op(ctrl.alu_op),
    .temp_a(temp_a),
    .temp_b(temp_b),
    .carry_in(flag_carry),
    .out(alu_out),
    .carry_out(alu_carry_out),
    .zero_out(alu_zero_out)
  );

  regs regs (
    .clk(clk),
    .clk_en(clk_en),
    .rst_n(rst_n),
    .ctrl(ctrl),
    .decoded(decoded),
    .int_vector(int_vector),
    .alu(alu_out),
    .alu_zero(alu_zero_out),
    .alu_carry(alu_carry_out),
    .memory_read_data(memory_read_data),
    .memory_read_en(memory_read_en),
    .memory_write_en(memory_write_en),
    .memory_addr(memory_addr),
    .memory_write_data(memory_write_data),
    .pc(rom_addr),
    .temp_a(temp_a),
    .temp_b(temp_b),
    .zero(flag_zero),
    .carry(flag_carry),
    .interrupt(flag_interrupt)
  );

endmodule

`default_nettype wire

// File: sim/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
  import isa_pkg::*;

  logic clk;
  logic clk_en;
  logic rst_n;
  code_addr_t rom_addr;
  instr_word_t rom_data;
  logic memory_read_en;
  logic memory_write_en;
  data_addr_t memory_addr;
  nibble_t memory_write_data;
  nibble_t memory_read_data;
  logic [3:0] interrupt_req;

  instr_word_t rom [256];
  nibble_t dmem [256];
  logic written [256];
  data_addr_t read_log [$];
  int write_count;
  data_addr_t last_wr_addr;
  nibble_t last_wr_data;

  int seed;
  int p;
  logic last_en;
  code_addr_t last_pc;
  code_addr_t prev_pc;
  code_addr_t ret_addr;
  code_addr_t eidi_addr;
  code_addr_t loop_addr;
  logic irq_open;
  int wc;
  int n;

  opcode_e ops [5];
  nibble_t op_a [5];
  nibble_t op_b [5];
  nibble_t exp_res [5];
  logic exp_c [5];
  logic exp_z [5];

  cpu #(
    .int_count(4)
  ) UUT (
    .clk(clk),
    .clk_en(clk_en),
    .rst_n(rst_n),
    .rom_addr(rom_addr),
    .rom_data(rom_data),
    .memory_read_en(memory_read_en),
    .memory_write_en(memory_write_en),
    .memory_addr(memory_addr),
    .memory_write_data(memory_write_data),
    .memory_read_data(memory_read_data),
    .interrupt_req(interrupt_req)
  );

  always #5 clk = ~clk;

  // combinational ROM and memory reads
  assign rom_data = rom[rom_addr];
  assign memory_read_data = dmem[memory_addr];

  function automatic nibble_t fill(data_addr_t a);
    return (a[3:0] + a[7:4]) ^ 4'ha;
  endfunction

  function automatic instr_word_t enc(opcode_e op, reg_sel_e sel, nibble_t nib);
    return {op, 2'b00, sel, nib};
  endfunction

  function automatic instr_word_t jmp(opcode_e op, code_addr_t target);
    return {op, target};
  endfunction

  task automatic check(input logic cond, input string msg);
    assert (cond) else begin
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic emit(input instr_word_t w);
    rom[p] = w;
    p++;
  endtask

  // conditional jump over the next instruction
  task automatic emit_skip(input opcode_e op);
    emit(jmp(op, code_addr_t'(p + 2)));
  endtask

  task automatic wait_pc(input code_addr_t target, input string what);
    n = 0;
    while (rom_addr != target) begin
      prev_pc = rom_addr;
      @(negedge clk);
      n++;
      if (n > 3000) timeout(what);
    end
  endtask

  task automatic build_program();
    int r;
    logic c;
    c = 1'b0;
    ops[0] = OP_ADD;
    ops[1] = OP_SUB;
    ops[2] = OP_AND;
    ops[3] = OP_OR;
    ops[4] = OP_XOR;
    for (int k = 0; k < 5; k++) begin
      op_a[k] = nibble_t'($random(seed));
      op_b[k] = nibble_t'($random(seed));
      case (k)
        0: begin
          r = int'(op_a[k]) + int'(op_b[k]);
          c = (r > 15);
        end
        1: begin
          r = int'(op_a[k]) - int'(op_b[k]);
          c = (r < 0);
        end
        2: r = int'(op_a[k] & op_b[k]);
        3: r = int'(op_a[k] | op_b[k]);
        default: r = int'(op_a[k] ^ op_b[k]);
      endcase
      // logic ops leave carry as it was
      exp_res[k] = nibble_t'(r & 15);
      exp_c[k] = c;
      exp_z[k] = ((r & 15) == 0);
    end
    rom[0] = jmp(OP_JP, 8'h10);
    rom[1] = enc(OP_RETI, REG_A, 4'd0);
    rom[2] = enc(OP_RETI, REG_A, 4'd0);
    rom[3] = enc(OP_ST, REG_A, 4'd0);
    rom[4] = enc(OP_RETI, REG_A, 4'd0);
    p = 16;
    emit(enc(OP_LDI, REG_XH, 4'd0));
    for (int k = 0; k < 5; k++) begin
      emit(enc(OP_LDI, REG_A, op_a[k]));
      emit(enc(OP_LDI, REG_B, op_b[k]));
      emit(enc(ops[k], REG_B, 4'd0));
      emit(enc(OP_LDI, REG_XL, nibble_t'(3 * k)));
      emit(enc(OP_ST, REG_A, 4'd0));
      emit(enc(OP_LDI, REG_XL, nibble_t'(3 * k + 1)));
      emit(enc(OP_LDI, REG_A, 4'd1));
      emit_skip(OP_JPC);
      emit(enc(OP_LDI, REG_A, 4'd0));
      emit(enc(OP_ST, REG_A, 4'd0));
      emit(enc(OP_LDI, REG_XL, nibble_t'(3 * k + 2)));
      emit(enc(OP_LDI, REG_A, 4'd1));
      emit_skip(OP_JPZ);
      emit(enc(OP_LDI, REG_A, 4'd0));
      emit(enc(OP_ST, REG_A, 4'd0));
    end
    // taken jumps skip the store to 0x1e
    emit(enc(OP_LDI, REG_XH, 4'd1));
    emit(enc(OP_LDI, REG_XL, 4'he));
    emit(enc(OP_LDI, REG_A, 4'hf));
    emit(enc(OP_LDI, REG_B, 4'd1));
    emit(enc(OP_ADD, REG_B, 4'd0));
    emit_skip(OP_JPC);
    emit(enc(OP_ST, REG_A, 4'd0));
    emit_skip(OP_JPZ);
    emit(enc(OP_ST, REG_A, 4'd0));
    // 1 + 1 clears both flags, so nothing is skipped
    emit(enc(OP_LDI, REG_XL, 4'hf));
    emit(enc(OP_LDI, REG_A, 4'd1));
    emit(enc(OP_ADD, REG_B, 4'd0));
    emit_skip(OP_JPC);
    emit(enc(OP_ST, REG_A, 4'd0));
    emit(enc(OP_LDI, REG_XL, 4'hd));
    emit_skip(OP_JPZ);
    emit(enc(OP_ST, REG_A, 4'd0));
    // copy the ADD result from 0x00 to 0x30
    emit(enc(OP_LDI, REG_XH, 4'd0));
    emit(enc(OP_LDI, REG_XL, 4'd0));
    emit(enc(OP_LD, REG_A, 4'd0));
    emit(enc(OP_LDI, REG_XH, 4'd3));
    emit(enc(OP_ST, REG_A, 4'd0));
    emit(enc(OP_LDI, REG_XH, 4'd2));
    emit(enc(OP_LDI, REG_XL, 4'd4));
    for (int k = 0; k < 4; k++) begin
      emit(enc(OP_LDPX, REG_A, 4'd0));
    end
    emit(enc(OP_ST, REG_A, 4'd0));
    eidi_addr = code_addr_t'(p);
    emit(enc(OP_EIDI, REG_A, 4'd1));
    loop_addr = code_addr_t'(p);
    emit(enc(OP_NOP, REG_A, 4'd0));
    emit(jmp(OP_JP, loop_addr));
  endtask

  // memory model commits on enabled edges
  always @(posedge clk) begin
    if (rst_n && clk_en) begin
      if (memory_write_en) begin
        dmem[memory_addr] <= memory_write_data;
        written[memory_addr] <= 1'b1;
        write_count <= write_count + 1;
        last_wr_addr <= memory_addr;
        last_wr_data <= memory_write_data;
      end
      if (memory_read_en && memory_addr[7:4] == 4'h2) begin
        read_log.push_back(memory_addr);
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && !last_en) begin
      check(rom_addr == last_pc, "rom_addr moved while clk_en was low");
    end
    // the reset jump at 0 passes through address 1
    if (rst_n && !irq_open && last_pc >= 8'h10) begin
      check(!(rom_addr inside {[8'd1:8'd4]}), "vector taken with interrupts disabled");
    end
    last_pc = rom_addr;
    clk_en = ($random(seed) & 32'd3) != 0;
    last_en = clk_en;
  end

  initial begin
    seed = 32'h68dc88c8;
    clk = 1'b0;
    clk_en = 1'b0;
    rst_n = 1'b0;
    interrupt_req = '0;
    last_en = 1'b1;
    last_pc = '0;
    prev_pc = '0;
    irq_open = 1'b0;
    write_count = 0;
    for (int i = 0; i < 256; i++) begin
      rom[i] = '0;
      dmem[i] = fill(data_addr_t'(i));
      written[i] = 1'b0;
    end
    build_program();
    repeat (5) @(negedge clk);
    check(rom_addr == 8'd0, "rom_addr not 0 after reset");
    check(!memory_read_en && !memory_write_en, "memory enable high after reset");
    rst_n = 1'b1;
    // pending while disabled
    interrupt_req = 4'b0001;
    wait_pc(eidi_addr, "the EIDI fetch");
    interrupt_req = '0;
    wait_pc(loop_addr, "the idle loop");
    for (int k = 0; k < 5; k++) begin
      check(written[3 * k] && dmem[3 * k] == exp_res[k], "wrong ALU result");
      check(written[3 * k + 1] && dmem[3 * k + 1] == {3'b000, exp_c[k]},
            "wrong carry flag");
      check(written[3 * k + 2] && dmem[3 * k + 2] == {3'b000, exp_z[k]},
            "wrong zero flag");
    end
    check(!written[8'h1e], "store on a taken jump path committed");
    check(written[8'h1f] && dmem[8'h1f] == 4'd2, "JPC fall-through store missing");
    check(written[8'h1d] && dmem[8'h1d] == 4'd2, "JPZ fall-through store missing");
    check(written[8'h30] && dmem[8'h30] == exp_res[0], "LD/ST round trip mismatch");
    check(read_log.size() == 4, "wrong number of LDPX reads");
    for (int i = 0; i < read_log.size(); i++) begin
      check(read_log[i] == data_addr_t'(8'h24 + i), "LDPX address not consecutive");
    end
    check(dmem[8'h28] == fill(8'h27), "LDPX loaded wrong data");
    irq_open = 1'b1;
    wc = write_count;
    // request 3 pending too, the lower index has to win
    interrupt_req = 4'b1100;
    wait_pc(8'd3, "the vector of request 2");
    ret_addr = prev_pc;
    check(ret_addr == loop_addr || ret_addr == loop_addr + 8'd1, "bad interrupt return address");
    n = 0;
    while (write_count == wc) begin
      @(negedge clk);
      n++;
      if (n > 3000) timeout("the handler store");
    end
    interrupt_req = '0;
    check(last_wr_addr == 8'h28 && last_wr_data == fill(8'h27), "handler store wrong");
    n = 0;
    while (rom_addr inside {[8'd3:8'd5]}) begin
      @(negedge clk);
      n++;
      if (n > 3000) timeout("the return from the handler");
    end
    check(rom_addr == ret_addr, "RETI did not return to the interrupted instruction");
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
verilog/isa_pkg.sv
verilog/uarch_pkg.sv
verilog/alu.sv
verilog/decode.sv
verilog/microcode.sv
verilog/regs.sv
verilog/cpu.sv
sim/tb_cpu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
( verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_cpu -o tb_cpu \
  && ./obj_dir/tb_cpu ) > sim.log 2>&1 || echo "Regression failed" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
